/* hdl/fpu_macros.svh */
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

`define FPU_XLEN        32
`define FPU_NREG        32
`define FPU_WB_STAGE    4   // Ops are written to the register file entering this stage.
`define FPU_LOAD_STAGE  3   // Memory data joins the result pipeline here.

// Major opcodes.
`define FPU_OP_FP       7'b1010011
`define FPU_OP_LOAD_FP  7'b0000111
`define FPU_OP_STORE_FP 7'b0100111

// Funct5 values under OP-FP.
`define FPU_F5_SGNJ     5'b00100
`define FPU_F5_CMP      5'b10100
`define FPU_F5_MV_XW    5'b11100
`define FPU_F5_MV_WX    5'b11110

`endif

/* hdl/fpu_pkg.sv */
`include "fpu_macros.svh"

package fpu_pkg;

    typedef logic [`FPU_XLEN-1:0] float_t;
    typedef logic [$clog2(`FPU_NREG)-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        sgn_copy,
        sgn_neg,
        sgn_xor
    } sgn_mode_e;

    typedef enum logic [1:0] {
        cmp_eq,
        cmp_lt,
        cmp_le
    } cmp_mode_e;

    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      use_rs1;
        logic      use_rs2;
        logic      reg_write;    // Writes a float register.
        logic      is_sgn;
        logic      is_cmp;
        logic      is_mv_wx;
        logic      is_mv_xw;
        logic      is_load;
        logic      is_store;
        sgn_mode_e sgn_mode;
        cmp_mode_e cmp_mode;
        float_t    int_data;     // Sampled with the instruction.
    } fpu_op_t;

endpackage

/* hdl/fpu_op_if.sv */
`timescale 1ns/100ps

interface fpu_op_if import fpu_pkg::*; ();

    fpu_op_t uop;    // Stage 0 op.

    modport src (output uop);
    modport dst (input uop);
    modport mon (input uop);

endinterface

/* hdl/fpu_decode.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_decode import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 is_legl,
    input  logic [`FPU_XLEN-1:0] inst,
    input  float_t               from_intreg,
    input  logic                 hazard,
    fpu_op_if.src                op
);

    logic [6:0] opcode;
    logic [4:0] funct5;
    logic [2:0] funct3;
    fpu_op_t    dec;

    assign opcode = inst[6:0];
    assign funct5 = inst[31:27];
    assign funct3 = inst[14:12];

    always_comb begin
        dec          = '0;
        dec.rd       = inst[11:7];
        dec.rs1      = inst[19:15];
        dec.rs2      = inst[24:20];
        dec.int_data = from_intreg;
        dec.sgn_mode = sgn_copy;
        dec.cmp_mode = cmp_eq;
        case (opcode)
            `FPU_OP_FP: begin
                case (funct5)
                    `FPU_F5_SGNJ: begin
                        dec.is_sgn  = (funct3 <= 3'd2);
                        dec.use_rs1 = 1'b1;
                        dec.use_rs2 = 1'b1;
                        case (funct3)
                            3'd1:    dec.sgn_mode = sgn_neg;
                            3'd2:    dec.sgn_mode = sgn_xor;
                            default: dec.sgn_mode = sgn_copy;
                        endcase
                    end
                    `FPU_F5_CMP: begin
                        dec.is_cmp  = (funct3 <= 3'd2);
                        dec.use_rs1 = 1'b1;
                        dec.use_rs2 = 1'b1;
                        case (funct3)
                            3'd2:    dec.cmp_mode = cmp_eq;
                            3'd1:    dec.cmp_mode = cmp_lt;
                            default: dec.cmp_mode = cmp_le;
                        endcase
                    end
                    `FPU_F5_MV_XW: begin
                        dec.is_mv_xw = (funct3 == 3'd0);
                        dec.use_rs1  = 1'b1;
                    end
                    `FPU_F5_MV_WX: dec.is_mv_wx = (funct3 == 3'd0);
                    default: ;
                endcase
            end
            `FPU_OP_LOAD_FP: dec.is_load = (funct3 == 3'b010);
            `FPU_OP_STORE_FP: begin
                dec.is_store = (funct3 == 3'b010);
                dec.use_rs2  = 1'b1;    // Store data; rs1 is the integer base.
            end
            default: ;
        endcase
        dec.reg_write = dec.is_sgn | dec.is_mv_wx | dec.is_load;
        dec.valid     = is_legl & ~hazard &
                        (dec.reg_write | dec.is_cmp | dec.is_mv_xw | dec.is_store);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op.uop.valid <= 1'b0;
        end else begin
            op.uop <= dec;    // A stalled slot becomes a bubble.
        end
    end

endmodule

/* hdl/fpu_regfile.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_regfile import fpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  reg_idx_t waddr,
    input  float_t   wdata,
    input  logic     we,
    output float_t   rdata1,
    output float_t   rdata2
);

    float_t regs [0:`FPU_NREG-1];

    // Read data lines up with stage 0; stage 4 forwarding covers a
    // write to the same register at the same edge.
    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
        rdata1 <= regs[raddr1];
        rdata2 <= regs[raddr2];
    end

endmodule

/* hdl/fpu_hazard_unit.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_hazard_unit import fpu_pkg::*; (
    fpu_op_if.mon                op,
    input  logic [`FPU_XLEN-1:0] inst,
    input  reg_idx_t             stage_rd [0:`FPU_WB_STAGE],
    input  logic [`FPU_WB_STAGE:0] stage_valid,
    input  logic [`FPU_WB_STAGE:0] stage_load,
    output logic                 hazard,
    output logic [2:0]           fwd_sel1,
    output logic [2:0]           fwd_sel2
);

    logic [6:0] opcode;
    logic [4:0] funct5;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       reads_rs1;
    logic       reads_rs2;

    assign opcode = inst[6:0];
    assign funct5 = inst[31:27];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign reads_rs1 = (opcode == `FPU_OP_FP) && (funct5 != `FPU_F5_MV_WX);
    assign reads_rs2 = ((opcode == `FPU_OP_FP) &&
                        (funct5 == `FPU_F5_SGNJ || funct5 == `FPU_F5_CMP)) ||
                       (opcode == `FPU_OP_STORE_FP);

    // Load data is not ready until LOAD_STAGE.
    always_comb begin
        hazard = 1'b0;
        for (int k = 0; k < `FPU_LOAD_STAGE - 1; k++) begin
            if (stage_valid[k] && stage_load[k]) begin
                if ((reads_rs1 && stage_rd[k] == rs1) || (reads_rs2 && stage_rd[k] == rs2)) begin
                    hazard = 1'b1;
                end
            end
        end
    end

    // Youngest writer wins, so scan from the oldest stage down.
    always_comb begin
        fwd_sel1 = 3'd0;
        fwd_sel2 = 3'd0;
        for (int k = `FPU_WB_STAGE; k >= 1; k--) begin
            if (op.uop.use_rs1 && stage_valid[k] && stage_rd[k] == op.uop.rs1) begin
                fwd_sel1 = 3'(k);
            end
            if (op.uop.use_rs2 && stage_valid[k] && stage_rd[k] == op.uop.rs2) begin
                fwd_sel2 = 3'(k);
            end
        end
    end

endmodule

/* hdl/fpu_exec.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_exec import fpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    fpu_op_if.dst      op,
    input  float_t     rdata1,
    input  float_t     rdata2,
    input  logic [2:0] fwd_sel1,
    input  logic [2:0] fwd_sel2,
    input  float_t     stage_result [1:`FPU_WB_STAGE],
    output float_t     sgn_result,
    output float_t     to_mem,
    output logic       mem_we,
    output float_t     to_intreg
);

    float_t opa;
    float_t opb;
    logic   sign;
    logic   any_nan;
    logic   both_zero;
    logic   eq;
    logic   lt;
    logic   cmp_res;

    always_comb begin
        opa = rdata1;
        opb = rdata2;
        for (int k = 1; k <= `FPU_WB_STAGE; k++) begin
            if (fwd_sel1 == 3'(k)) begin
                opa = stage_result[k];
            end
            if (fwd_sel2 == 3'(k)) begin
                opb = stage_result[k];
            end
        end
    end

    always_comb begin
        case (op.uop.sgn_mode)
            sgn_neg: sign = ~opb[31];
            sgn_xor: sign = opa[31] ^ opb[31];
            default: sign = opb[31];
        endcase
    end

    assign sgn_result = {sign, opa[30:0]};

    assign any_nan   = (&opa[30:23] && |opa[22:0]) || (&opb[30:23] && |opb[22:0]);
    assign both_zero = ~|{opa[30:0], opb[30:0]};    // +0 and -0 match.
    assign eq        = !any_nan && (opa == opb || both_zero);

    always_comb begin
        if (any_nan || both_zero) begin
            lt = 1'b0;
        end else if (opa[31] != opb[31]) begin
            lt = opa[31];
        end else if (opa[31]) begin
            lt = opa[30:0] > opb[30:0];    // Negative magnitudes reverse.
        end else begin
            lt = opa[30:0] < opb[30:0];
        end
    end

    always_comb begin
        case (op.uop.cmp_mode)
            cmp_eq:  cmp_res = eq;
            cmp_lt:  cmp_res = lt;
            cmp_le:  cmp_res = lt | eq;
            default: cmp_res = 1'b0;
        endcase
    end

    assign to_mem = opb;
    assign mem_we = op.uop.valid & op.uop.is_store;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            to_intreg <= '0;
        end else if (op.uop.valid && op.uop.is_cmp) begin
            to_intreg <= {{(`FPU_XLEN-1){1'b0}}, cmp_res};
        end else if (op.uop.valid && op.uop.is_mv_xw) begin
            to_intreg <= opa;    // Raw bits.
        end
    end

endmodule

/* hdl/fpu_writeback.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_writeback import fpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fpu_op_t                stage0_op,
    input  float_t                 sgn_result,
    input  float_t                 from_mem,
    output reg_idx_t               stage_rd [0:`FPU_WB_STAGE],
    output logic [`FPU_WB_STAGE:0] stage_valid,
    output logic [`FPU_WB_STAGE:0] stage_load,
    output float_t                 stage_result [1:`FPU_WB_STAGE],
    output reg_idx_t               wb_addr,
    output float_t                 wb_data,
    output logic                   wb_we
);

    logic [`FPU_WB_STAGE:1] st_valid;
    logic [`FPU_WB_STAGE:1] st_wr;
    logic [`FPU_WB_STAGE:1] st_load;
    reg_idx_t               st_rd [1:`FPU_WB_STAGE];
    float_t                 st_result [1:`FPU_WB_STAGE];
    float_t                 mem_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_valid <= '0;
            st_wr    <= '0;
            st_load  <= '0;
        end else begin
            st_valid <= {st_valid[`FPU_WB_STAGE-1:1], stage0_op.valid};
            st_wr    <= {st_wr[`FPU_WB_STAGE-1:1], stage0_op.reg_write};
            st_load  <= {st_load[`FPU_WB_STAGE-1:1], stage0_op.is_load};
        end
    end

    // Empty slots between stages are kept for future arithmetic units.
    always_ff @(posedge clk) begin
        mem_q        <= from_mem;    // Load data cycle.
        st_rd[1]     <= stage0_op.rd;
        st_result[1] <= stage0_op.is_mv_wx ? stage0_op.int_data : sgn_result;
        for (int k = 2; k <= `FPU_WB_STAGE; k++) begin
            st_rd[k] <= st_rd[k-1];
            if (k == `FPU_LOAD_STAGE && st_load[k-1]) begin
                st_result[k] <= mem_q;
            end else begin
                st_result[k] <= st_result[k-1];
            end
        end
    end

    // Forward taps; valid means a pending float register write.
    always_comb begin
        stage_rd[0]    = stage0_op.rd;
        stage_valid[0] = stage0_op.valid & stage0_op.reg_write;
        stage_load[0]  = stage0_op.is_load;
        for (int k = 1; k <= `FPU_WB_STAGE; k++) begin
            stage_rd[k]     = st_rd[k];
            stage_valid[k]  = st_valid[k] & st_wr[k];
            stage_load[k]   = st_load[k];
            stage_result[k] = st_result[k];
        end
    end

    // Written as the op enters the writeback stage.
    assign wb_addr = st_rd[`FPU_WB_STAGE-1];
    assign wb_data = st_result[`FPU_WB_STAGE-1];
    assign wb_we   = st_valid[`FPU_WB_STAGE-1] & st_wr[`FPU_WB_STAGE-1];

endmodule

/* hdl/fpu_top.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_top import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 is_legl,
    input  logic [`FPU_XLEN-1:0] inst,
    input  logic [`FPU_XLEN-1:0] from_intreg,
    input  logic [`FPU_XLEN-1:0] from_mem,
    output logic [`FPU_XLEN-1:0] to_mem,
    output logic                 mem_we,
    output logic [`FPU_XLEN-1:0] to_intreg,
    output logic                 hazard
);

    float_t                 rdata1;
    float_t                 rdata2;
    float_t                 sgn_result;
    logic [2:0]             fwd_sel1;
    logic [2:0]             fwd_sel2;
    reg_idx_t               stage_rd [0:`FPU_WB_STAGE];
    logic [`FPU_WB_STAGE:0] stage_valid;
    logic [`FPU_WB_STAGE:0] stage_load;
    float_t                 stage_result [1:`FPU_WB_STAGE];
    reg_idx_t               wb_addr;
    float_t                 wb_data;
    logic                   wb_we;

    fpu_op_if op_bus ();

    fpu_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .is_legl     (is_legl),
        .inst        (inst),
        .from_intreg (from_intreg),
        .hazard      (hazard),
        .op          (op_bus.src)
    );

    fpu_hazard_unit u_hazard (
        .op          (op_bus.mon),
        .inst        (inst),
        .stage_rd    (stage_rd),
        .stage_valid (stage_valid),
        .stage_load  (stage_load),
        .hazard      (hazard),
        .fwd_sel1    (fwd_sel1),
        .fwd_sel2    (fwd_sel2)
    );

    fpu_regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst[19:15]),
        .raddr2 (inst[24:20]),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .we     (wb_we),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    fpu_exec u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .op           (op_bus.dst),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .fwd_sel1     (fwd_sel1),
        .fwd_sel2     (fwd_sel2),
        .stage_result (stage_result),
        .sgn_result   (sgn_result),
        .to_mem       (to_mem),
        .mem_we       (mem_we),
        .to_intreg    (to_intreg)
    );

    fpu_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage0_op    (op_bus.uop),
        .sgn_result   (sgn_result),
        .from_mem     (from_mem),
        .stage_rd     (stage_rd),
        .stage_valid  (stage_valid),
        .stage_load   (stage_load),
        .stage_result (stage_result),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_we        (wb_we)
    );

endmodule

/* verif/fpu_checker.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_checker import fpu_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 is_legl,
    input logic [`FPU_XLEN-1:0] inst,
    input logic [`FPU_XLEN-1:0] from_intreg,
    input logic [`FPU_XLEN-1:0] from_mem,
    input logic [`FPU_XLEN-1:0] to_mem,
    input logic                 mem_we,
    input logic [`FPU_XLEN-1:0] to_intreg,
    input logic                 hazard
);

    float_t   shadow [0:`FPU_NREG-1];    // Architectural float registers.
    float_t   a;
    float_t   b;
    float_t   exp_val;
    float_t   exp_q1;
    float_t   exp_q2;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t ld_rd1;
    reg_idx_t ld_rd2;
    logic     is_fp;
    logic     is_sgn;
    logic     is_cmp;
    logic     is_mvxw;
    logic     is_mvwx;
    logic     is_load;
    logic     is_store;
    logic     r1_use;
    logic     r2_use;
    logic     acc;
    logic     seen_acc;
    logic     st_q1;
    logic     int_q1;
    logic     int_q2;
    logic     ld_q1;
    logic     ld_q2;
    logic     hit1;
    logic     hit2;
    logic     nan;
    logic     cmp_bit;
    logic     sign;
    int       fail_count = 0;

    function automatic logic is_nan(input float_t f);
        return (f[30:23] == 8'hff) && (f[22:0] != 23'd0);
    endfunction

    // Signed position on the real line; both zeros map to 0.
    function automatic logic signed [32:0] order_key(input float_t f);
        if (f[31]) begin
            return -$signed({2'b00, f[30:0]});
        end
        return $signed({2'b00, f[30:0]});
    endfunction

    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign is_fp    = inst[6:0] == `FPU_OP_FP;
    assign is_sgn   = is_fp && inst[31:27] == `FPU_F5_SGNJ;
    assign is_cmp   = is_fp && inst[31:27] == `FPU_F5_CMP;
    assign is_mvxw  = is_fp && inst[31:27] == `FPU_F5_MV_XW;
    assign is_mvwx  = is_fp && inst[31:27] == `FPU_F5_MV_WX;
    assign is_load  = inst[6:0] == `FPU_OP_LOAD_FP;
    assign is_store = inst[6:0] == `FPU_OP_STORE_FP;
    assign r1_use   = is_sgn || is_cmp || is_mvxw;
    assign r2_use   = is_sgn || is_cmp || is_store;
    assign acc      = rst_n && is_legl && !hazard;
    assign hit1     = is_legl && ((r1_use && rs1 == ld_rd1) || (r2_use && rs2 == ld_rd1));
    assign hit2     = is_legl && ((r1_use && rs1 == ld_rd2) || (r2_use && rs2 == ld_rd2));

    always_comb begin
        a   = shadow[rs1];
        b   = shadow[rs2];
        nan = is_nan(a) || is_nan(b);
        case (inst[14:12])
            3'd2:    cmp_bit = !nan && order_key(a) == order_key(b);    // feq.
            3'd1:    cmp_bit = !nan && order_key(a) < order_key(b);     // flt.
            default: cmp_bit = !nan && order_key(a) <= order_key(b);    // fle.
        endcase
        case (inst[14:12])
            3'd0:    sign = b[31];
            3'd1:    sign = !b[31];
            default: sign = a[31] ^ b[31];
        endcase
        if (is_mvwx) begin
            exp_val = from_intreg;
        end else if (is_mvxw) begin
            exp_val = a;
        end else if (is_store) begin
            exp_val = b;
        end else if (is_cmp) begin
            exp_val = {31'd0, cmp_bit};
        end else begin
            exp_val = {sign, a[30:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_acc <= 1'b0;
            st_q1    <= 1'b0;
            int_q1   <= 1'b0;
            int_q2   <= 1'b0;
            ld_q1    <= 1'b0;
            ld_q2    <= 1'b0;
        end else begin
            seen_acc <= seen_acc | acc;
            st_q1    <= acc && is_store;
            int_q1   <= acc && (is_cmp || is_mvxw);
            int_q2   <= int_q1;
            ld_q1    <= acc && is_load;
            ld_q2    <= ld_q1;
            ld_rd1   <= rd;
            ld_rd2   <= ld_rd1;
            exp_q1   <= exp_val;
            exp_q2   <= exp_q1;
            if (acc && (is_sgn || is_mvwx)) begin
                shadow[rd] <= exp_val;
            end
            if (ld_q2) begin
                shadow[ld_rd2] <= from_mem;    // Load data cycle.
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_acc |-> !hazard && !mem_we)
        else begin
            $error("%0t: hazard or mem_we went high before any instruction was accepted", $time);
            fail_count++;
        end

    a_mem_we: assert property (@(posedge clk) disable iff (!rst_n) mem_we == st_q1)
        else begin
            $error("[FAIL] %0t mem_we expected %b actual %b", $time, $sampled(st_q1),
                   $sampled(mem_we));
            fail_count++;
        end

    a_to_mem: assert property (@(posedge clk) disable iff (!rst_n)
        st_q1 |-> to_mem == exp_q1)
        else begin
            $error("[FAIL] %0t to_mem expected %h actual %h", $time, $sampled(exp_q1),
                   $sampled(to_mem));
            fail_count++;
        end

    a_to_intreg: assert property (@(posedge clk) disable iff (!rst_n)
        int_q2 |-> to_intreg == exp_q2)
        else begin
            $error("[FAIL] %0t to_intreg expected %h actual %h", $time, $sampled(exp_q2),
                   $sampled(to_intreg));
            fail_count++;
        end

    a_load_use: assert property (@(posedge clk) disable iff (!rst_n)
        (ld_q1 && hit1) || (ld_q2 && hit2) |-> hazard)
        else begin
            $error("%0t: consumer of a load in stage 0 or 1 was not stalled", $time);
            fail_count++;
        end

    a_stall_len: assert property (@(posedge clk) disable iff (!rst_n)
        hazard ##1 hazard |=> !hazard)
        else begin
            $error("%0t: hazard stayed high for more than 2 cycles", $time);
            fail_count++;
        end

endmodule

/* verif/fpu_tb.sv */
`timescale 1ns/100ps
`include "fpu_macros.svh"

module fpu_tb;

    localparam int max_wait = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 is_legl;
    logic [`FPU_XLEN-1:0] inst;
    logic [`FPU_XLEN-1:0] from_intreg;
    logic [`FPU_XLEN-1:0] from_mem;
    logic [`FPU_XLEN-1:0] to_mem;
    logic                 mem_we;
    logic [`FPU_XLEN-1:0] to_intreg;
    logic                 hazard;
    logic [31:0]          lfsr;
    int                   timeouts;
    int                   tests_failed;
    int                   errs_before;

    fpu_top DUT (.*);

    bind fpu_top fpu_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fp_op(input logic [4:0] f5, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f5, 2'b00, rs2, rs1, f3, rd, `FPU_OP_FP};    // Single format.
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd);
        return {12'd0, 5'd0, 3'b010, rd, `FPU_OP_LOAD_FP};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2);
        return {7'd0, rs2, 5'd0, 3'b010, 5'd0, `FPU_OP_STORE_FP};
    endfunction

    // Holds the instruction until an edge where hazard is low.
    task automatic issue(input logic [31:0] word, input logic [31:0] ival);
        int waited;
        inst        <= word;
        is_legl     <= 1'b1;
        from_intreg <= ival;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (hazard && waited < max_wait);
        if (hazard) begin
            $display("%0t: instruction %h was never accepted, hazard stayed high", $time, word);
            timeouts++;
        end
        is_legl <= 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        issue(fp_op(`FPU_F5_MV_WX, 3'd0, rd, 5'd0, 5'd0), val);
    endtask

    task automatic store_reg(input logic [4:0] rs);
        issue(store_word(rs), 32'd0);
    endtask

    task automatic compare_all(input logic [4:0] x, input logic [4:0] y);
        for (int f3 = 0; f3 < 3; f3++) begin
            issue(fp_op(`FPU_F5_CMP, 3'(f3), 5'd0, x, y), 32'd0);
        end
    endtask

    task automatic report(input int num, input string name);
        int errs;
        repeat (`FPU_WB_STAGE + 2) @(posedge clk);    // Let the pipeline empty.
        errs = DUT.chk.fail_count + timeouts - errs_before;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
            tests_failed++;
        end
        errs_before = DUT.chk.fail_count + timeouts;
    endtask

    initial begin
        lfsr         = 32'd69;
        rst_n        = 1'b0;
        is_legl      = 1'b0;
        inst         = '0;
        from_intreg  = '0;
        from_mem     = '0;
        timeouts     = 0;
        tests_failed = 0;
        errs_before  = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        inst <= store_word(5'd1);    // Not legal, so nothing issues.
        report(1, "idle after reset");

        for (int r = 1; r <= 4; r++) begin
            write_reg(5'(r), rand_bits(32));
        end
        for (int r = 1; r <= 4; r++) begin
            store_reg(5'(r));    // Distance 4.
        end
        write_reg(5'd5, rand_bits(32));
        store_reg(5'd5);
        report(2, "move and store");

        repeat (4) begin
            write_reg(5'd1, rand_bits(32));
            write_reg(5'd2, rand_bits(32));
            for (int m = 0; m < 3; m++) begin
                issue(fp_op(`FPU_F5_SGNJ, 3'(m), 5'(3 + m), 5'd1, 5'd2), 32'd0);
            end
            for (int m = 0; m < 3; m++) begin
                store_reg(5'(3 + m));
            end
        end
        report(3, "sign injection");

        write_reg(5'd10, rand_bits(32));
        write_reg(5'd11, rand_bits(32));
        write_reg(5'd12, 32'h0000_0000);
        write_reg(5'd13, 32'h8000_0000);
        write_reg(5'd14, 32'h7fc0_0001);
        write_reg(5'd15, 32'hbf80_0000);    // -1.0
        write_reg(5'd16, 32'hc000_0000);    // -2.0
        compare_all(5'd10, 5'd11);
        compare_all(5'd11, 5'd10);
        compare_all(5'd12, 5'd13);
        compare_all(5'd10, 5'd14);
        compare_all(5'd14, 5'd14);
        compare_all(5'd15, 5'd16);
        compare_all(5'd16, 5'd15);
        compare_all(5'd10, 5'd10);
        issue(fp_op(`FPU_F5_MV_XW, 3'd0, 5'd0, 5'd10, 5'd0), 32'd0);
        report(4, "compare and move to integer");

        repeat (3) begin
            write_reg(5'd20, rand_bits(32));
            write_reg(5'd21, rand_bits(32));
            issue(fp_op(`FPU_F5_SGNJ, 3'd1, 5'd22, 5'd20, 5'd21), 32'd0);
            issue(fp_op(`FPU_F5_SGNJ, 3'd2, 5'd23, 5'd22, 5'd21), 32'd0);
            issue(fp_op(`FPU_F5_SGNJ, 3'd0, 5'd24, 5'd22, 5'd23), 32'd0);
            issue(fp_op(`FPU_F5_SGNJ, 3'd2, 5'd25, 5'd22, 5'd24), 32'd0);
            issue(fp_op(`FPU_F5_SGNJ, 3'd1, 5'd26, 5'd22, 5'd25), 32'd0);
            for (int r = 22; r <= 26; r++) begin
                store_reg(5'(r));
            end
        end
        report(5, "forwarding distances 1 to 4");

        repeat (3) begin
            issue(load_word(5'd7), 32'd0);
            from_mem <= rand_bits(32);    // Held through the data cycle.
            store_reg(5'd7);
            issue(load_word(5'd8), 32'd0);
            from_mem <= rand_bits(32);
            issue(fp_op(`FPU_F5_SGNJ, 3'd1, 5'd9, 5'd8, 5'd8), 32'd0);
            store_reg(5'd9);
        end
        report(6, "load use stall");

        $display("tests run 6, tests failed %0d, assertion failures %0d, timeouts %0d",
                 tests_failed, DUT.chk.fail_count, timeouts);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fpu_op_if.sv
hdl/fpu_decode.sv
hdl/fpu_regfile.sv
hdl/fpu_hazard_unit.sv
hdl/fpu_exec.sv
hdl/fpu_writeback.sv
hdl/fpu_top.sv
verif/fpu_checker.sv
verif/fpu_tb.sv

/* Bender.yml */
package:
  name: fpu_slice

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_pkg.sv
      - hdl/fpu_op_if.sv
      - hdl/fpu_decode.sv
      - hdl/fpu_regfile.sv
      - hdl/fpu_hazard_unit.sv
      - hdl/fpu_exec.sv
      - hdl/fpu_writeback.sv
      - hdl/fpu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/fpu_checker.sv
      - verif/fpu_tb.sv
